// ==== icache_sub.f ====
+incdir+design
design/icache_pkg.sv
design/ic_tag_array.sv
design/ic_data_array.sv
design/icache.sv
design/l2_line_store.sv
design/ifetch_top.sv
bench/ifetch_assert.sv
bench/ifetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the fetch subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f icache_sub.f \
  --top-module ifetch_tb \
  -o ifetch_sim \
  && ./obj_dir/ifetch_sim | tee /dev/stderr | grep -q "Test passed" \
  && exit 0 \
  || exit 1

// ==== bench/ifetch_tb.sv ====
// directed testbench for the fetch subsystem, with a reference model of tags and victims
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module ifetch_tb
  import icache_pkg::*;
();

  localparam int NUM_FETCHES = 48;
  localparam int WATCHDOG_NS = NUM_FETCHES * (`L2_LATENCY + 8) * 4 + `L2_LINES * 4 + 2000;

  logic                clk;
  logic                reset_n;
  logic                s0_valid;
  logic [`VADDR_W-1:0] s0_vaddr;
  logic                s0_ready;
  logic [`VADDR_W-1:0] s1_paddr;
  logic                s1_tlb_miss;
  logic                s2_valid;
  logic [`VADDR_W-1:0] s2_addr;
  ic_line_t            s2_data;
  logic                s2_miss;
  logic [`VADDR_W-1:0] s2_miss_vaddr;
  logic                load_en;
  logic [7:0]          load_index;
  ic_line_t            load_data;

  // reference model
  ic_line_t             l2_copy [`L2_LINES];
  logic [`IC_TAG_W-1:0] m_tag [64][2];
  logic                 m_valid [64][2];
  logic                 m_victim [64];

  ic_addr_u b_addr [8];
  logic     b_tlb [8];
  int       errors;
  int       checks;
  int       l2_req_cycles;

  ifetch_top ifetch_top_inst (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_s0_valid      (s0_valid),
    .i_s0_vaddr      (s0_vaddr),
    .o_s0_ready      (s0_ready),
    .i_s1_paddr      (s1_paddr),
    .i_s1_tlb_miss   (s1_tlb_miss),
    .o_s2_valid      (s2_valid),
    .o_s2_addr       (s2_addr),
    .o_s2_data       (s2_data),
    .o_s2_miss       (s2_miss),
    .o_s2_miss_vaddr (s2_miss_vaddr),
    .i_load_en       (load_en),
    .i_load_index    (load_index),
    .i_load_data     (load_data)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (ifetch_top_inst.l2_req_valid) begin
      l2_req_cycles <= l2_req_cycles + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Test failed");
    $finish;
  end

  // ============================================================
  // compare tasks
  // ============================================================
  task automatic report_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic check_hit(input ic_addr_u a, input ic_line_t exp);
    checks++;
    if (s2_valid !== 1'b1 || s2_miss !== 1'b0 || s2_addr !== a.raw || s2_data !== exp) begin
      report_mismatch($sformatf("hit %h: valid %b miss %b addr %h data %h exp %h",
        a.raw, s2_valid, s2_miss, s2_addr, s2_data, exp));
    end
  endtask

  task automatic check_miss(input ic_addr_u a);
    checks++;
    if (s2_miss !== 1'b1 || s2_valid !== 1'b0 || s2_miss_vaddr !== a.raw) begin
      report_mismatch($sformatf("miss %h: valid %b miss %b addr %h",
        a.raw, s2_valid, s2_miss, s2_miss_vaddr));
    end
  endtask

  task automatic check_quiet();
    checks++;
    if (s2_valid !== 1'b0 || s2_miss !== 1'b0) begin
      report_mismatch($sformatf("stage 2 active: valid %b miss %b", s2_valid, s2_miss));
    end
  endtask

  task automatic check_ready(input logic exp);
    checks++;
    if (s0_ready !== exp) begin
      report_mismatch($sformatf("fetch ready %b, expected %b", s0_ready, exp));
    end
  endtask

  // ============================================================
  // model
  // ============================================================
  // low eight bits of the line address
  function automatic logic [7:0] l2_index(input ic_addr_u a);
    return a.raw[`IC_OFFSET_W +: 8];
  endfunction

  // fixed page mapping that moves only tag bits
  function automatic ic_addr_u translate(input ic_addr_u v);
    ic_addr_u p;
    p         = v;
    p.fld.tag = v.fld.tag ^ 22'h2a5;
    return p;
  endfunction

  function automatic ic_addr_u make_addr(input logic [21:0] tag, input logic [5:0] idx);
    ic_addr_u a;
    a.fld.tag    = tag;
    a.fld.index  = idx;
    a.fld.offset = 4'($urandom());
    return a;
  endfunction

  // 1 hit, 2 miss with refill, 3 TLB miss
  function automatic int predict(input ic_addr_u a, input logic tlb);
    int       s;
    int       v;
    ic_addr_u p;
    s = a.fld.index;
    p = translate(a);
    if (tlb) begin
      return 3;
    end
    for (int w = 0; w < 2; w++) begin
      if (m_valid[s][w] && m_tag[s][w] == p.fld.tag) begin
        return 1;
      end
    end
    v = m_victim[s] ? 1 : 0;
    m_tag[s][v]   = p.fld.tag;
    m_valid[s][v] = 1'b1;
    m_victim[s]   = ~m_victim[s];
    return 2;
  endfunction

  task automatic clear_model();
    for (int s = 0; s < 64; s++) begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
      m_victim[s]   = 1'b0;
    end
  endtask

  // ============================================================
  // stimulus
  // ============================================================
  task automatic wait_ready();
    @(posedge clk);
    while (!s0_ready) begin
      @(posedge clk);
    end
  endtask

  // consecutive fetches; anything behind a refill miss expects no output
  task automatic run_burst(input int n);
    int       kind [8];
    logic     after_miss;
    ic_addr_u pa;
    after_miss = 1'b0;
    for (int i = 0; i < n; i++) begin
      kind[i]    = after_miss ? 0 : predict(b_addr[i], b_tlb[i]);
      after_miss = (kind[i] == 2);
    end
    wait_ready();
    s0_valid <= 1'b1;
    s0_vaddr <= b_addr[0].raw;
    for (int c = 0; c < n + 2; c++) begin
      @(posedge clk);
      if (c < n && s0_ready !== 1'b1) begin
        errors++;
        $display("fetch %0d of a burst was not accepted", c);
      end
      if (c >= 2) begin
        case (kind[c-2])
          1: check_hit(b_addr[c-2], l2_copy[l2_index(translate(b_addr[c-2]))]);
          2: begin
            check_miss(b_addr[c-2]);
            check_ready(1'b0);
          end
          3: begin
            check_miss(b_addr[c-2]);
            check_ready(1'b1);
          end
          default: check_quiet();
        endcase
      end
      s1_tlb_miss <= (c < n) ? b_tlb[c] : 1'b0;
      if (c < n) begin
        pa        = translate(b_addr[c]);
        s1_paddr <= pa.raw;
      end
      if (c + 1 < n) begin
        s0_vaddr <= b_addr[c+1].raw;
      end else begin
        s0_valid <= 1'b0;
      end
    end
  endtask

  task automatic fetch_one(input ic_addr_u a, input logic tlb);
    b_addr[0] = a;
    b_tlb[0]  = tlb;
    run_burst(1);
  endtask

  // ============================================================
  // directed tests
  // ============================================================
  task automatic test_cold_miss(output ic_addr_u a);
    a = make_addr(22'($urandom()), 6'd3);
    fetch_one(a, 1'b0);
    fetch_one(a, 1'b0);
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 4; i++) begin
      b_addr[4+i] = make_addr(22'($urandom()), 6'(10 + i));
      fetch_one(b_addr[4+i], 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      b_addr[i] = b_addr[4+i];
      b_tlb[i]  = 1'b0;
    end
    run_burst(4);
  endtask

  // A, B, C share a set; C evicts A, so B hits and A misses again
  task automatic test_replacement();
    ic_addr_u    a;
    ic_addr_u    b;
    ic_addr_u    c;
    logic [21:0] t;
    t = {20'($urandom()), 2'b00};
    a = make_addr(t, 6'd20);
    b = make_addr(t + 22'd1, 6'd20);
    c = make_addr(t + 22'd2, 6'd20);
    fetch_one(a, 1'b0);
    fetch_one(b, 1'b0);
    fetch_one(c, 1'b0);
    fetch_one(b, 1'b0);
    fetch_one(a, 1'b0);
    fetch_one(c, 1'b0);
  endtask

  task automatic test_tlb_miss();
    ic_addr_u a;
    int       req_before;
    a = make_addr(22'($urandom()), 6'd30);
    req_before = l2_req_cycles;
    fetch_one(a, 1'b1);
    repeat (`L2_LATENCY + 2) @(posedge clk);
    if (l2_req_cycles != req_before) begin
      errors++;
      $display("an L2 request was raised for a TLB miss");
    end
    fetch_one(a, 1'b0);
    fetch_one(a, 1'b0);
  endtask

  task automatic test_flush();
    b_addr[0] = make_addr(22'($urandom()), 6'd40);
    b_addr[1] = make_addr(22'($urandom()), 6'd41);
    b_tlb[0]  = 1'b0;
    b_tlb[1]  = 1'b0;
    run_burst(2);
    // flushed fetch never reached the cache
    fetch_one(b_addr[1], 1'b0);
    fetch_one(b_addr[1], 1'b0);
  endtask

  // reset lands while a refill is still waiting on the L2 store
  task automatic test_reset(input ic_addr_u old);
    ic_addr_u busy;
    busy = make_addr(22'($urandom()), 6'd50);
    fetch_one(busy, 1'b0);
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (4) begin
      @(posedge clk);
      check_ready(1'b1);
      check_quiet();
      if (ifetch_top_inst.l2_req_valid !== 1'b0) begin
        errors++;
        $display("L2 request still raised during reset");
      end
    end
    reset_n <= 1'b1;
    clear_model();
    fetch_one(old, 1'b0);
    fetch_one(old, 1'b0);
  endtask

  initial begin
    ic_addr_u first;
    void'($urandom(93792));
    clk         = 1'b0;
    reset_n     = 1'b0;
    s0_valid    = 1'b0;
    s0_vaddr    = '0;
    s1_paddr    = '0;
    s1_tlb_miss = 1'b0;
    load_en     = 1'b0;
    load_index  = '0;
    load_data   = '0;
    errors        = 0;
    checks        = 0;
    l2_req_cycles = 0;
    clear_model();

    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    // boot load of the whole L2 store
    for (int i = 0; i < `L2_LINES; i++) begin
      @(posedge clk);
      l2_copy[i] = {$urandom(), $urandom(), $urandom(), $urandom()};
      load_en    <= 1'b1;
      load_index <= 8'(i);
      load_data  <= l2_copy[i];
    end
    @(posedge clk);
    load_en <= 1'b0;

    test_cold_miss(first);
    test_back_to_back();
    test_replacement();
    test_tlb_miss();
    test_flush();
    test_reset(first);

    repeat (2) @(posedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/ifetch_assert.sv ====
// handshake and state checks on the instruction cache, attached to every icache by bind
`timescale 1ns/1ps
`default_nettype none

module ifetch_assert
  import icache_pkg::*;
(
  input logic        i_clk,
  input logic        i_reset_n,
  input ic_state_e   i_state,
  input logic        i_s0_ready,
  input logic        i_s2_valid,
  input logic        i_s2_miss,
  input logic        i_req_valid,
  input logic [31:0] i_req_addr,
  input logic        i_req_ready
);

  // request held until the L2 store takes it
  req_held_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_req_valid && !i_req_ready) |=> (i_req_valid && $stable(i_req_addr)))
    else $error("L2 request dropped or changed before it was accepted");

  hit_miss_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_s2_valid && i_s2_miss))
    else $error("stage 2 reported a hit and a miss together");

  busy_ready_a : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_state != IC_IDLE) |-> !i_s0_ready)
    else $error("fetch ready high while a refill is running");

endmodule

bind icache ifetch_assert assert_u (
  .i_clk       (i_clk),
  .i_reset_n   (i_reset_n),
  .i_state     (r_state),
  .i_s0_ready  (o_s0_ready),
  .i_s2_valid  (o_s2_valid),
  .i_s2_miss   (o_s2_miss),
  .i_req_valid (o_l2_req_valid),
  .i_req_addr  (o_l2_req_addr),
  .i_req_ready (i_l2_req_ready)
);

`default_nettype wire

// ==== design/ifetch_top.sv ====
// fetch subsystem top joining the instruction cache to the L2 line store
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module ifetch_top
  import icache_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_s0_valid,
  input  logic [`VADDR_W-1:0]          i_s0_vaddr,
  output logic                         o_s0_ready,
  input  logic [`VADDR_W-1:0]          i_s1_paddr,
  input  logic                         i_s1_tlb_miss,

  output logic                         o_s2_valid,
  output logic [`VADDR_W-1:0]          o_s2_addr,
  output ic_line_t                     o_s2_data,
  output logic                         o_s2_miss,
  output logic [`VADDR_W-1:0]          o_s2_miss_vaddr,

  input  logic                         i_load_en,
  input  logic [$clog2(`L2_LINES)-1:0] i_load_index,
  input  ic_line_t                     i_load_data
);

  logic                l2_req_valid;
  logic [`VADDR_W-1:0] l2_req_addr;
  logic                l2_req_ready;
  logic                l2_resp_valid;
  ic_line_t            l2_resp_data;

  icache icache_u (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_s0_valid      (i_s0_valid),
    .i_s0_vaddr      (i_s0_vaddr),
    .o_s0_ready      (o_s0_ready),
    .i_s1_paddr      (i_s1_paddr),
    .i_s1_tlb_miss   (i_s1_tlb_miss),
    .o_s2_valid      (o_s2_valid),
    .o_s2_addr       (o_s2_addr),
    .o_s2_data       (o_s2_data),
    .o_s2_miss       (o_s2_miss),
    .o_s2_miss_vaddr (o_s2_miss_vaddr),
    .o_l2_req_valid  (l2_req_valid),
    .o_l2_req_addr   (l2_req_addr),
    .i_l2_req_ready  (l2_req_ready),
    .i_l2_resp_valid (l2_resp_valid),
    .i_l2_resp_data  (l2_resp_data)
  );

  l2_line_store l2_u (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_load_en    (i_load_en),
    .i_load_index (i_load_index),
    .i_load_data  (i_load_data),
    .i_req_valid  (l2_req_valid),
    .i_req_addr   (l2_req_addr),
    .o_req_ready  (l2_req_ready),
    .o_resp_valid (l2_resp_valid),
    .o_resp_data  (l2_resp_data)
  );

endmodule

`default_nettype wire

// ==== design/l2_line_store.sv ====
// on-chip L2 line memory, loaded before fetching and answering refills after a fixed delay
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module l2_line_store
  import icache_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  input  logic                         i_load_en,
  input  logic [$clog2(`L2_LINES)-1:0] i_load_index,
  input  ic_line_t                     i_load_data,

  input  logic                         i_req_valid,
  input  logic [`VADDR_W-1:0]          i_req_addr,
  output logic                         o_req_ready,

  output logic                         o_resp_valid,
  output ic_line_t                     o_resp_data
);

  localparam int IDX_W     = $clog2(`L2_LINES);
  localparam int TAG_LOW_W = IDX_W - `IC_INDEX_W;
  localparam int CNT_W     = $clog2(`L2_LATENCY + 1);

  ic_line_t         r_mem [`L2_LINES];
  ic_addr_u         w_req_addr;
  logic [IDX_W-1:0] w_req_index;
  logic [IDX_W-1:0] r_index;
  logic [CNT_W-1:0] r_cnt;
  logic             w_accept;

  // low line-address bits, which spill past the cache index into the tag
  assign w_req_addr.raw = i_req_addr;
  assign w_req_index    = {w_req_addr.fld.tag[TAG_LOW_W-1:0], w_req_addr.fld.index};

  assign o_req_ready = (r_cnt == '0);
  assign w_accept    = i_req_valid & o_req_ready;

  // ============================================================
  // latency counter
  // ============================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cnt        <= '0;
      o_resp_valid <= 1'b0;
    end else begin
      if (w_accept) begin
        r_cnt <= CNT_W'(`L2_LATENCY);
      end else if (r_cnt != '0) begin
        r_cnt <= r_cnt - 1'b1;
      end
      o_resp_valid <= (r_cnt == CNT_W'(1));
    end
  end

  // ============================================================
  // storage
  // ============================================================
  always_ff @(posedge i_clk) begin
    if (i_load_en) begin
      r_mem[i_load_index] <= i_load_data;
    end
    if (w_accept) begin
      r_index <= w_req_index;
    end
    // line leaves with the last count
    if (r_cnt == CNT_W'(1)) begin
      o_resp_data <= r_mem[r_index];
    end
  end

endmodule

`default_nettype wire

// ==== design/icache.sv ====
// two-way instruction cache with a three-stage lookup and a single-miss L2 refill FSM
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache
  import icache_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_s0_valid,
  input  logic [`VADDR_W-1:0] i_s0_vaddr,
  output logic                o_s0_ready,

  input  logic [`VADDR_W-1:0] i_s1_paddr,
  input  logic                i_s1_tlb_miss,

  output logic                o_s2_valid,
  output logic [`VADDR_W-1:0] o_s2_addr,
  output ic_line_t            o_s2_data,
  output logic                o_s2_miss,
  output logic [`VADDR_W-1:0] o_s2_miss_vaddr,

  output logic                o_l2_req_valid,
  output logic [`VADDR_W-1:0] o_l2_req_addr,
  input  logic                i_l2_req_ready,
  input  logic                i_l2_resp_valid,
  input  ic_line_t            i_l2_resp_data
);

  localparam int SETS     = 1 << `IC_INDEX_W;
  localparam int VICTIM_W = (`IC_WAYS > 1) ? $clog2(`IC_WAYS) : 1;

  ic_state_e r_state;

  ic_addr_u w_s0_addr;
  ic_addr_u r_s1_vaddr;
  ic_addr_u w_s1_paddr;
  ic_addr_u r_s2_vaddr;
  ic_addr_u r_miss_paddr;

  logic                r_s1_valid;
  logic                w_s1_live;
  logic                w_s1_hit;
  logic                w_refill_start;
  logic [`IC_WAYS-1:0] w_s1_hit_vec;

  logic                r_s2_valid;
  logic                r_s2_miss;
  logic [`IC_WAYS-1:0] r_s2_hit_vec;
  ic_line_t            w_s2_line [`IC_WAYS];
  ic_line_t            w_s2_sel;

  logic                w_refill_fire;
  logic [VICTIM_W-1:0] w_refill_way;
  logic [`IC_WAYS-1:0] w_way_wr;
  logic [VICTIM_W-1:0] r_victim [SETS];

  assign w_s0_addr.raw  = i_s0_vaddr;
  assign w_s1_paddr.raw = i_s1_paddr;

  assign w_refill_fire = (r_state == IC_WAIT) & i_l2_resp_valid;
  assign w_refill_way  = r_victim[r_miss_paddr.fld.index];

  // ============================================================
  // ways
  // ============================================================
  for (genvar w = 0; w < `IC_WAYS; w++) begin : g_way
    logic [`IC_TAG_W-1:0] w_tag;
    logic                 w_tag_valid;

    assign w_way_wr[w] = w_refill_fire & (w_refill_way == VICTIM_W'(w));

    ic_tag_array tag_u (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_wr        (w_way_wr[w]),
      .i_wr_index  (r_miss_paddr.fld.index),
      .i_wr_tag    (r_miss_paddr.fld.tag),
      .i_rd_index  (w_s0_addr.fld.index),
      .o_tag       (w_tag),
      .o_tag_valid (w_tag_valid)
    );

    assign w_s1_hit_vec[w] = w_tag_valid & (w_tag == w_s1_paddr.fld.tag);

    ic_data_array data_u (
      .i_clk      (i_clk),
      .i_wr       (w_way_wr[w]),
      .i_wr_index (r_miss_paddr.fld.index),
      .i_wr_line  (i_l2_resp_data),
      .i_rd_index (r_s1_vaddr.fld.index),
      .o_line     (w_s2_line[w])
    );
  end

  // ============================================================
  // stage 1 compare
  // ============================================================
  // anything in stage 1 while a refill runs is flushed
  assign w_s1_live      = r_s1_valid & (r_state == IC_IDLE);
  assign w_s1_hit       = (|w_s1_hit_vec) & ~i_s1_tlb_miss;
  assign w_refill_start = w_s1_live & ~w_s1_hit & ~i_s1_tlb_miss;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_miss  <= 1'b0;
    end else begin
      r_s1_valid <= i_s0_valid & o_s0_ready;
      r_s2_valid <= w_s1_live & w_s1_hit;
      r_s2_miss  <= w_s1_live & ~w_s1_hit;
    end
  end

  // address pipeline follows the tag read every cycle
  always_ff @(posedge i_clk) begin
    r_s1_vaddr   <= w_s0_addr;
    r_s2_vaddr   <= r_s1_vaddr;
    r_s2_hit_vec <= w_s1_hit_vec;
    if (w_refill_start) begin
      r_miss_paddr <= w_s1_paddr;
    end
  end

  // ============================================================
  // stage 2 select
  // ============================================================
  always_comb begin
    w_s2_sel = '0;
    for (int w = 0; w < `IC_WAYS; w++) begin
      w_s2_sel = w_s2_sel | ({$bits(ic_line_t){r_s2_hit_vec[w]}} & w_s2_line[w]);
    end
  end

  assign o_s2_valid      = r_s2_valid;
  assign o_s2_addr       = r_s2_vaddr.raw;
  assign o_s2_data       = w_s2_sel;
  assign o_s2_miss       = r_s2_miss;
  assign o_s2_miss_vaddr = r_s2_vaddr.raw;

  // ============================================================
  // refill FSM
  // ============================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IC_IDLE;
    end else begin
      case (r_state)
        IC_IDLE: begin
          if (w_refill_start) begin
            r_state <= IC_REQ;
          end
        end
        IC_REQ: begin
          if (i_l2_req_ready) begin
            r_state <= IC_WAIT;
          end
        end
        IC_WAIT: begin
          if (i_l2_resp_valid) begin
            r_state <= IC_IDLE;
          end
        end
        default: r_state <= IC_IDLE;
      endcase
    end
  end

  // round-robin victim per set
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < SETS; s++) begin
        r_victim[s] <= '0;
      end
    end else if (w_refill_fire) begin
      r_victim[r_miss_paddr.fld.index] <= w_refill_way + 1'b1;
    end
  end

  assign o_s0_ready     = (r_state == IC_IDLE);
  assign o_l2_req_valid = (r_state == IC_REQ);
  assign o_l2_req_addr  = {r_miss_paddr.raw[`VADDR_W-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

// ==== design/ic_data_array.sv ====
// line data store for one cache way, read from the stage-1 index so data lands in stage 2
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module ic_data_array
  import icache_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_wr,
  input  logic [`IC_INDEX_W-1:0] i_wr_index,
  input  ic_line_t               i_wr_line,
  input  logic [`IC_INDEX_W-1:0] i_rd_index,
  output ic_line_t               o_line
);

  localparam int SETS = 1 << `IC_INDEX_W;

  ic_line_t r_lines [SETS];

  // qualified by the tag valid bits of the same way
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_lines[i_wr_index] <= i_wr_line;
    end
    o_line <= r_lines[i_rd_index];
  end

endmodule

`default_nettype wire

// ==== design/ic_tag_array.sv ====
// tag store for one cache way, written on refill and read one cycle ahead of the compare
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module ic_tag_array (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  logic                   i_wr,
  input  logic [`IC_INDEX_W-1:0] i_wr_index,
  input  logic [`IC_TAG_W-1:0]   i_wr_tag,
  input  logic [`IC_INDEX_W-1:0] i_rd_index,
  output logic [`IC_TAG_W-1:0]   o_tag,
  output logic                   o_tag_valid
);

  localparam int SETS = 1 << `IC_INDEX_W;

  logic [`IC_TAG_W-1:0] r_tags [SETS];
  logic [SETS-1:0]      r_valid;
  logic                 w_bypass;

  // same-set write forwards to the read port
  assign w_bypass = i_wr & (i_wr_index == i_rd_index);

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tags[i_wr_index] <= i_wr_tag;
    end
    o_tag <= w_bypass ? i_wr_tag : r_tags[i_rd_index];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      o_tag_valid <= 1'b0;
    end else begin
      if (i_wr) begin
        r_valid[i_wr_index] <= 1'b1;
      end
      o_tag_valid <= w_bypass | r_valid[i_rd_index];
    end
  end

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
// shared fetch address, line and refill state types, imported by the cache and L2 store
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  // one fetch address word, seen whole or split for indexing
  typedef union packed {
    logic [`VADDR_W-1:0] raw;
    struct packed {
      logic [`IC_TAG_W-1:0]    tag;
      logic [`IC_INDEX_W-1:0]  index;
      logic [`IC_OFFSET_W-1:0] offset;
    } fld;
  } ic_addr_u;

  // full cache line, byte 0 in the low bits
  typedef logic [`IC_LINE_BYTES*8-1:0] ic_line_t;

  // miss handling
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_REQ,
    IC_WAIT
  } ic_state_e;

endpackage

`default_nettype wire

// ==== design/icache_defines.svh ====
// cache geometry and L2 latency macros, included by the package and every RTL file
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ============================================================
// address split
// ============================================================
`define VADDR_W       32
`define IC_LINE_BYTES 16
`define IC_OFFSET_W   4
`define IC_INDEX_W    6
`define IC_TAG_W      22

// ============================================================
// organisation and backing store
// ============================================================
`define IC_WAYS       2

// request accept to response pulse, in cycles
`define L2_LATENCY    3
`define L2_LINES      256

`endif
